// ==== files.f ====
logic/l2_ret_pkg.sv
logic/l2_ecc_encode.sv
logic/l2_data_array.sv
logic/l2_ret_flop.sv
logic/l2_ecc_correct.sv
logic/l2_ret_top.sv
test/l2_ret_properties.sv
test/l2_ret_tb.sv

// ==== test/l2_ret_tb.sv ====
// ----------------------------------------------------------
// L2 data return path testbench
// Table driven writes and reads with injected bit flips,
// reference SEC-DED encoder and memory model
// ----------------------------------------------------------
`default_nettype none

module l2_ret_tb;

   localparam int index_width = 4;
   localparam int table_len   = 54;
   localparam logic [1:0] op_wr    = 2'b01;
   localparam logic [1:0] op_rd    = 2'b10;
   localparam logic [1:0] op_wr_rd = 2'b11;

   logic                    rclk;
   logic                    reset;
   logic                    wr_en;
   logic [index_width-1:0]  wr_index;
   l2_ret_pkg::line_data_t  wr_data;
   l2_ret_pkg::array_word_t flip_mask;
   logic                    rd_en;
   logic [index_width-1:0]  rd_index;
   logic                    rd_valid;
   l2_ret_pkg::line_data_t  rd_data;
   l2_ret_pkg::lane_mask_t  corr_err;
   l2_ret_pkg::lane_mask_t  uncorr_err;

   // Stimulus table, one row per cycle
   logic [1:0]              tab_op     [table_len];
   logic [index_width-1:0]  tab_index  [table_len];
   l2_ret_pkg::array_word_t tab_mask   [table_len];
   l2_ret_pkg::lane_mask_t  tab_corr   [table_len];
   l2_ret_pkg::lane_mask_t  tab_uncorr [table_len];
   string                   tab_name   [table_len];
   int                      row_count;

   // Memory model, written line and stored codewords
   l2_ret_pkg::line_data_t  model_data [2**index_width];
   l2_ret_pkg::array_word_t model_word [2**index_width];

   // Reads in flight
   l2_ret_pkg::line_data_t  exp_data_q[$];
   l2_ret_pkg::lane_mask_t  exp_corr_q[$];
   l2_ret_pkg::lane_mask_t  exp_uncorr_q[$];
   string                   exp_name_q[$];

   logic [15:0] lfsr_state;
   int          error_count;

   l2_ret_top #(
      .index_width (index_width)
   ) i_l2_ret_top (
      .rclk       (rclk),
      .reset      (reset),
      .wr_en      (wr_en),
      .wr_index   (wr_index),
      .wr_data    (wr_data),
      .flip_mask  (flip_mask),
      .rd_en      (rd_en),
      .rd_index   (rd_index),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .corr_err   (corr_err),
      .uncorr_err (uncorr_err)
   );

   initial begin
      rclk = 1'b0;
      forever #4 rclk = ~rclk;
   end

   // 16 bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per data bit
   task automatic random_line(output l2_ret_pkg::line_data_t d);
      for (int b = 0; b < 128; b++) begin
         d[b] = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // Hamming word over positions 1 to 38, data fills non powers of two
   function automatic logic [38:0] ref_code(input logic [31:0] d);
      logic [6:0] chk;
      int         j;
      chk = '0;
      j = 0;
      for (int p = 1; p <= 38; p++) begin
         if ((p & (p - 1)) != 0) begin
            for (int i = 0; i < 6; i++) begin
               if (p[i]) chk[i] = chk[i] ^ d[j];
            end
            j++;
         end
      end
      // Overall parity over data and check bits 0 to 5
      chk[6] = ^{d, chk[5:0]};
      return {d, chk};
   endfunction

   function automatic l2_ret_pkg::array_word_t ref_line(input l2_ret_pkg::line_data_t d);
      l2_ret_pkg::array_word_t w;
      for (int k = 0; k < 4; k++) begin
         w[39*k +: 39] = ref_code(d[32*k +: 32]);
      end
      return w;
   endfunction

   // Flip masks in the array word layout
   function automatic l2_ret_pkg::array_word_t data_flip(input int k, input int j);
      return l2_ret_pkg::array_word_t'(1) << (39*k + 7 + j);
   endfunction

   function automatic l2_ret_pkg::array_word_t check_flip(input int k, input int i);
      return l2_ret_pkg::array_word_t'(1) << (39*k + i);
   endfunction

   // Uncorrectable words come back raw, all others as written
   function automatic l2_ret_pkg::line_data_t expected_line(input int idx,
                                                            input l2_ret_pkg::lane_mask_t bad);
      l2_ret_pkg::line_data_t d;
      for (int k = 0; k < 4; k++) begin
         d[32*k +: 32] = bad[k] ? model_word[idx][39*k + 7 +: 32] : model_data[idx][32*k +: 32];
      end
      return d;
   endfunction

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (actual !== expected) begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic add_row(input logic [1:0] op, input int idx, input l2_ret_pkg::array_word_t mask,
                          input l2_ret_pkg::lane_mask_t corr,
                          input l2_ret_pkg::lane_mask_t uncorr, input string name);
      tab_op[row_count]     = op;
      tab_index[row_count]  = idx;
      tab_mask[row_count]   = mask;
      tab_corr[row_count]   = corr;
      tab_uncorr[row_count] = uncorr;
      tab_name[row_count]   = name;
      row_count++;
   endtask

   // Write with a flip mask, then read it back
   task automatic error_case(input int idx, input l2_ret_pkg::array_word_t mask,
                             input l2_ret_pkg::lane_mask_t corr,
                             input l2_ret_pkg::lane_mask_t uncorr, input string name);
      add_row(op_wr, idx, mask, '0, '0, {name, "_wr"});
      add_row(op_rd, idx, '0, corr, uncorr, name);
   endtask

   task automatic build_table();
      row_count = 0;
      for (int i = 0; i < 16; i++) add_row(op_wr, i, '0, '0, '0, $sformatf("clean_wr_%0d", i));
      // Back to back reads of every index
      for (int i = 0; i < 16; i++) add_row(op_rd, i, '0, '0, '0, $sformatf("clean_rd_%0d", i));
      error_case(1, data_flip(0, 0), 4'b0001, 4'b0000, "data_lo_w0");
      error_case(2, data_flip(1, 15), 4'b0010, 4'b0000, "data_mid_w1");
      error_case(3, data_flip(3, 31), 4'b1000, 4'b0000, "data_hi_w3");
      error_case(4, data_flip(2, 31), 4'b0100, 4'b0000, "data_hi_w2");
      error_case(6, check_flip(2, 0), 4'b0100, 4'b0000, "check0_w2");
      error_case(7, check_flip(3, 6), 4'b1000, 4'b0000, "check6_w3");
      error_case(8, check_flip(0, 5), 4'b0001, 4'b0000, "check5_w0");
      error_case(9, data_flip(1, 3) | data_flip(1, 20), 4'b0000, 4'b0010, "double_data_w1");
      error_case(10, data_flip(2, 0) | check_flip(2, 2), 4'b0000, 4'b0100, "double_mixed_w2");
      error_case(11, data_flip(0, 16) | data_flip(3, 1) | data_flip(3, 30),
                 4'b0001, 4'b1000, "single_w0_double_w3");
      // Same cycle read and write returns the old line
      add_row(op_wr_rd, 5, '0, '0, '0, "same_cycle_old");
      add_row(op_rd, 5, '0, '0, '0, "same_cycle_new");
   endtask

   task automatic apply_row(input int r);
      l2_ret_pkg::line_data_t line;
      wr_en     = tab_op[r][0];
      rd_en     = tab_op[r][1];
      wr_index  = tab_index[r];
      rd_index  = tab_index[r];
      flip_mask = tab_mask[r];
      // Expected values are taken before the model sees the write
      if (tab_op[r][1]) begin
         exp_data_q.push_back(expected_line(tab_index[r], tab_uncorr[r]));
         exp_corr_q.push_back(tab_corr[r]);
         exp_uncorr_q.push_back(tab_uncorr[r]);
         exp_name_q.push_back(tab_name[r]);
      end
      if (tab_op[r][0]) begin
         random_line(line);
         wr_data = line;
         model_data[tab_index[r]] = line;
         model_word[tab_index[r]] = ref_line(line) ^ tab_mask[r];
      end
   endtask

   // Outputs settle after the rising edge, sampled on the falling edge
   initial begin
      forever begin
         @(negedge rclk);
         if (rd_valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
               $display("rd_valid at time %0t with no read outstanding", $time);
               error_count++;
            end else begin
               check_value({exp_name_q[0], " data"}, exp_data_q.pop_front(), rd_data);
               check_value({exp_name_q[0], " corr_err"}, exp_corr_q.pop_front(), corr_err);
               check_value({exp_name_q[0], " uncorr_err"}, exp_uncorr_q.pop_front(), uncorr_err);
               void'(exp_name_q.pop_front());
            end
         end
      end
   end

   initial begin
      #((table_len + 20) * 8 * 2);
      $display("Watchdog expired before the test sequence completed");
      $display("Finished with errors");
      $finish;
   end

   initial begin
      reset       = 1'b1;
      wr_en       = 1'b0;
      wr_index    = '0;
      wr_data     = '0;
      flip_mask   = '0;
      rd_en       = 1'b0;
      rd_index    = '0;
      lfsr_state  = 16'd60786;
      error_count = 0;
      build_table();
      repeat (8) @(posedge rclk);
      #1;
      reset = 1'b0;
      for (int r = 0; r < row_count; r++) begin
         apply_row(r);
         @(posedge rclk);
         #1;
      end
      wr_en     = 1'b0;
      rd_en     = 1'b0;
      flip_mask = '0;
      // Drain the pipeline, three reads can still be in flight
      for (int n = 0; n < 8 && exp_data_q.size() != 0; n++) @(posedge rclk);
      if (exp_data_q.size() != 0) begin
         $display("%0d reads never returned rd_valid", exp_data_q.size());
         error_count++;
      end
      repeat (3) @(posedge rclk);
      $display("Errors: %0d", error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/l2_ret_properties.sv ====
// ----------------------------------------------------------
// L2 return path assertions
// Read latency, flag exclusivity and reset behavior,
// bound to the top level and to the C8 corrector
// ----------------------------------------------------------
`default_nettype none

module l2_ret_properties #(
   parameter int latency = 3
) (
   input wire                    rclk,
   input wire                    reset,
   input wire                    req,
   input wire                    rd_valid,
   input l2_ret_pkg::lane_mask_t corr_err,
   input l2_ret_pkg::lane_mask_t uncorr_err
);

   // Every request returns exactly latency edges later
   assert_req_to_valid: assert property (@(posedge rclk) disable iff (reset)
      req |-> ##latency rd_valid)
      else $error("read request produced no rd_valid after %0d cycles", latency);

   // No strobe without a matching request
   assert_valid_from_req: assert property (@(posedge rclk) disable iff (reset)
      rd_valid |-> $past(req, latency))
      else $error("rd_valid seen without a request %0d cycles earlier", latency);

   // A word is either corrected or uncorrectable, never both
   assert_flags_disjoint: assert property (@(posedge rclk) disable iff (reset)
      (corr_err & uncorr_err) == '0)
      else $error("corr_err and uncorr_err set for the same word");

   // Flags only travel with a valid return
   assert_flags_idle: assert property (@(posedge rclk) disable iff (reset)
      !rd_valid |-> (corr_err == '0 && uncorr_err == '0))
      else $error("error flags set while rd_valid is low");

   assert_reset_quiet: assert property (@(posedge rclk)
      reset |=> !rd_valid)
      else $error("rd_valid high during reset");

endmodule

// Full pipeline from the read request at the top
bind l2_ret_top l2_ret_properties #(.latency(3)) i_top_properties (
   .rclk(rclk), .reset(reset), .req(rd_en), .rd_valid(rd_valid),
   .corr_err(corr_err), .uncorr_err(uncorr_err)
);

// C8 stage alone
bind l2_ecc_correct l2_ret_properties #(.latency(1)) i_c8_properties (
   .rclk(rclk), .reset(reset), .req(valid_c7), .rd_valid(rd_valid),
   .corr_err(corr_err), .uncorr_err(uncorr_err)
);

`default_nettype wire

// ==== logic/l2_ret_top.sv ====
// ----------------------------------------------------------
// L2 data return path top level
// Encoder, data array, C7 return register and C8 corrector
// ----------------------------------------------------------
`default_nettype none

module l2_ret_top #(
   parameter int index_width = 4
) (
   input  wire                     rclk,
   input  wire                     reset,
   input  wire                     wr_en,
   input  wire [index_width-1:0]   wr_index,
   input  l2_ret_pkg::line_data_t  wr_data,
   input  l2_ret_pkg::array_word_t flip_mask,
   input  wire                     rd_en,
   input  wire [index_width-1:0]   rd_index,
   output logic                    rd_valid,
   output l2_ret_pkg::line_data_t  rd_data,
   output l2_ret_pkg::lane_mask_t  corr_err,
   output l2_ret_pkg::lane_mask_t  uncorr_err
);

   // Write cycle codeword
   l2_ret_pkg::array_word_t enc_word;

   // C6 array output
   l2_ret_pkg::array_word_t array_word_c6;
   logic                    valid_c6;

   // C7 return register
   l2_ret_pkg::line_data_t  data_c7;
   l2_ret_pkg::line_ecc_t   ecc_c7;
   logic                    valid_c7;

   l2_ecc_encode i_l2_ecc_encode (
      .wr_data  (wr_data),
      .enc_word (enc_word)
   );

   l2_data_array #(
      .index_width (index_width)
   ) i_l2_data_array (
      .rclk          (rclk),
      .reset         (reset),
      .wr_en         (wr_en),
      .wr_index      (wr_index),
      .enc_word      (enc_word),
      .flip_mask     (flip_mask),
      .rd_en         (rd_en),
      .rd_index      (rd_index),
      .array_word_c6 (array_word_c6),
      .valid_c6      (valid_c6)
   );

   l2_ret_flop i_l2_ret_flop (
      .rclk          (rclk),
      .reset         (reset),
      .array_word_c6 (array_word_c6),
      .valid_c6      (valid_c6),
      .data_c7       (data_c7),
      .ecc_c7        (ecc_c7),
      .valid_c7      (valid_c7)
   );

   l2_ecc_correct i_l2_ecc_correct (
      .rclk       (rclk),
      .reset      (reset),
      .data_c7    (data_c7),
      .ecc_c7     (ecc_c7),
      .valid_c7   (valid_c7),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid),
      .corr_err   (corr_err),
      .uncorr_err (uncorr_err)
   );

endmodule

`default_nettype wire

// ==== logic/l2_ecc_correct.sv ====
// ----------------------------------------------------------
// L2 ECC check and correct, C8
// Per word syndrome, single error correction, double error
// detection, registered line and error flags
// ----------------------------------------------------------
`default_nettype none

module l2_ecc_correct (
   input  wire                     rclk,
   input  wire                     reset,
   input  l2_ret_pkg::line_data_t  data_c7,
   input  l2_ret_pkg::line_ecc_t   ecc_c7,
   input  wire                     valid_c7,
   output l2_ret_pkg::line_data_t  rd_data,
   output logic                    rd_valid,
   output l2_ret_pkg::lane_mask_t  corr_err,
   output l2_ret_pkg::lane_mask_t  uncorr_err
);

   // Recomputed Hamming check bits of one received word
   function automatic logic [l2_ret_pkg::lane_syn_width-1:0] calc_check(
      input l2_ret_pkg::lane_data_t d
   );
      logic [l2_ret_pkg::lane_syn_width-1:0] c;
      c = '0;
      for (int j = 0; j < l2_ret_pkg::lane_data_width; j++) begin
         for (int i = 0; i < l2_ret_pkg::lane_syn_width; i++) begin
            if (l2_ret_pkg::data_pos[j][i]) begin
               c[i] = c[i] ^ d[j];
            end
         end
      end
      return c;
   endfunction

   l2_ret_pkg::line_data_t data_fix_c7;
   l2_ret_pkg::lane_mask_t corr_c7;
   l2_ret_pkg::lane_mask_t uncorr_c7;

   genvar k;

   generate
      for (k = 0; k < l2_ret_pkg::lane_count; k++) begin : g_lane
         l2_ret_pkg::lane_data_t                lane_data;
         l2_ret_pkg::lane_ecc_t                 lane_ecc;
         logic [l2_ret_pkg::lane_syn_width-1:0] syn;
         logic                                  par;
         logic                                  fixable;
         l2_ret_pkg::lane_data_t                lane_fix;

         assign lane_data = data_c7[k*l2_ret_pkg::lane_data_width +:
                                    l2_ret_pkg::lane_data_width];
         assign lane_ecc  = ecc_c7[k*l2_ret_pkg::lane_ecc_width +:
                                   l2_ret_pkg::lane_ecc_width];

         // Syndrome points at the failing code position
         assign syn = calc_check(lane_data) ^ lane_ecc[l2_ret_pkg::lane_syn_width-1:0];
         // Overall parity over the full codeword, zero when clean
         assign par = ^{lane_data, lane_ecc};

         // Odd parity with a position inside the word is one bad bit
         // A zero syndrome here means check bit 6 itself flipped
         assign fixable = par && (syn <= l2_ret_pkg::code_pos_max);

         // Flip the data bit whose position matches the syndrome
         // Check bit positions match no data bit and leave data alone
         always_comb begin
            for (int j = 0; j < l2_ret_pkg::lane_data_width; j++) begin
               lane_fix[j] = lane_data[j] ^ (fixable && (syn == l2_ret_pkg::data_pos[j]));
            end
         end

         assign data_fix_c7[k*l2_ret_pkg::lane_data_width +: l2_ret_pkg::lane_data_width] =
            lane_fix;

         assign corr_c7[k] = fixable;
         // Even parity with a nonzero syndrome is a double error,
         // an out of range position with odd parity is also fatal
         assign uncorr_c7[k] = (!par && (syn != '0)) ||
                               (par && (syn > l2_ret_pkg::code_pos_max));
      end
   endgenerate

   // Corrected line, no reset on the datapath
   always_ff @(posedge rclk) begin
      rd_data <= data_fix_c7;
   end

   // Strobe and flags, flags only with a valid return
   always_ff @(posedge rclk) begin
      if (reset) begin
         rd_valid   <= 1'b0;
         corr_err   <= '0;
         uncorr_err <= '0;
      end else begin
         rd_valid   <= valid_c7;
         corr_err   <= valid_c7 ? corr_c7 : '0;
         uncorr_err <= valid_c7 ? uncorr_c7 : '0;
      end
   end

endmodule

`default_nettype wire

// ==== logic/l2_ret_flop.sv ====
// ----------------------------------------------------------
// L2 return register, C7
// Splits the array word into data and check vectors
// ----------------------------------------------------------
`default_nettype none

module l2_ret_flop (
   input  wire                     rclk,
   input  wire                     reset,
   input  l2_ret_pkg::array_word_t array_word_c6,
   input  wire                     valid_c6,
   output l2_ret_pkg::line_data_t  data_c7,
   output l2_ret_pkg::line_ecc_t   ecc_c7,
   output logic                    valid_c7
);

   l2_ret_pkg::line_data_t data_c6;
   l2_ret_pkg::line_ecc_t  ecc_c6;

   genvar k;

   // Codeword k carries data word k over check field k
   generate
      for (k = 0; k < l2_ret_pkg::lane_count; k++) begin : g_split
         assign {data_c6[k*l2_ret_pkg::lane_data_width +: l2_ret_pkg::lane_data_width],
                 ecc_c6[k*l2_ret_pkg::lane_ecc_width +: l2_ret_pkg::lane_ecc_width]} =
            array_word_c6[k*l2_ret_pkg::lane_code_width +: l2_ret_pkg::lane_code_width];
      end
   endgenerate

   // Return datapath
   always_ff @(posedge rclk) begin
      data_c7 <= data_c6;
      ecc_c7  <= ecc_c6;
   end

   always_ff @(posedge rclk) begin
      if (reset) begin
         valid_c7 <= 1'b0;
      end else begin
         valid_c7 <= valid_c6;
      end
   end

endmodule

`default_nettype wire

// ==== logic/l2_data_array.sv ====
// ----------------------------------------------------------
// L2 data array
// Stores encoded array words with a diagnostic flip mask,
// registered read output in C6
// ----------------------------------------------------------
`default_nettype none

module l2_data_array #(
   parameter int index_width = 4
) (
   input  wire                     rclk,
   input  wire                     reset,
   input  wire                     wr_en,
   input  wire [index_width-1:0]   wr_index,
   input  l2_ret_pkg::array_word_t enc_word,
   input  l2_ret_pkg::array_word_t flip_mask,
   input  wire                     rd_en,
   input  wire [index_width-1:0]   rd_index,
   output l2_ret_pkg::array_word_t array_word_c6,
   output logic                    valid_c6
);

   localparam int depth = 2 ** index_width;

   // Storage, one array word per index
   l2_ret_pkg::array_word_t mem [depth];

   // Write port
   // The flip mask injects errors into the stored codewords
   always_ff @(posedge rclk) begin
      if (wr_en) begin
         mem[wr_index] <= enc_word ^ flip_mask;
      end
   end

   // Read port
   // Nonblocking update gives old data on a same cycle write
   always_ff @(posedge rclk) begin
      if (rd_en) begin
         array_word_c6 <= mem[rd_index];
      end
   end

   // Read strobe into C6
   always_ff @(posedge rclk) begin
      if (reset) begin
         valid_c6 <= 1'b0;
      end else begin
         valid_c6 <= rd_en;
      end
   end

endmodule

`default_nettype wire

// ==== logic/l2_ecc_encode.sv ====
// ----------------------------------------------------------
// L2 write line ECC encoder
// Computes SEC-DED check bits for each 32-bit word and
// packs the four codewords into one array word
// ----------------------------------------------------------
`default_nettype none

module l2_ecc_encode (
   input  l2_ret_pkg::line_data_t  wr_data,
   output l2_ret_pkg::array_word_t enc_word
);

   // Check bits of one word
   // Bits 0 to 5 are Hamming parity over the data positions,
   // bit 6 covers every data and check bit of the word
   function automatic l2_ret_pkg::lane_ecc_t calc_ecc(input l2_ret_pkg::lane_data_t d);
      l2_ret_pkg::lane_ecc_t e;
      e = '0;
      for (int j = 0; j < l2_ret_pkg::lane_data_width; j++) begin
         for (int i = 0; i < l2_ret_pkg::lane_syn_width; i++) begin
            // Data bit j feeds check bit i when its position has bit i set
            if (l2_ret_pkg::data_pos[j][i]) begin
               e[i] = e[i] ^ d[j];
            end
         end
      end
      // Overall parity for double error detection
      e[l2_ret_pkg::lane_ecc_width-1] = ^{d, e[l2_ret_pkg::lane_syn_width-1:0]};
      return e;
   endfunction

   genvar k;

   generate
      for (k = 0; k < l2_ret_pkg::lane_count; k++) begin : g_lane
         l2_ret_pkg::lane_data_t lane_data;
         l2_ret_pkg::lane_ecc_t  lane_ecc;

         // Word k of the line
         assign lane_data = wr_data[k*l2_ret_pkg::lane_data_width +:
                                    l2_ret_pkg::lane_data_width];
         assign lane_ecc  = calc_ecc(lane_data);

         // Codeword k with data above its check field
         assign enc_word[k*l2_ret_pkg::lane_code_width +: l2_ret_pkg::lane_code_width] =
            {lane_data, lane_ecc};
      end
   endgenerate

endmodule

`default_nettype wire

// ==== logic/l2_ret_pkg.sv ====
// ----------------------------------------------------------
// L2 data return path shared definitions
// Widths, vector types and the SEC-DED codeword layout
// ----------------------------------------------------------
`default_nettype none

package l2_ret_pkg;

   // Protected words per cache line
   localparam int lane_count      = 4;
   localparam int lane_data_width = 32;
   localparam int lane_ecc_width  = 7;
   // Hamming check bits, the overall parity bit excluded
   localparam int lane_syn_width  = 6;
   // One codeword is data above check bits
   localparam int lane_code_width = lane_data_width + lane_ecc_width;

   localparam int line_data_width  = lane_count * lane_data_width;
   localparam int line_ecc_width   = lane_count * lane_ecc_width;
   localparam int array_word_width = lane_count * lane_code_width;

   // Highest valid code position in a word
   localparam logic [lane_syn_width-1:0] code_pos_max = 6'd38;

   // Code position of each data bit, skipping the powers of two
   localparam logic [lane_syn_width-1:0] data_pos [lane_data_width] = '{
      6'd3,  6'd5,  6'd6,  6'd7,  6'd9,  6'd10, 6'd11, 6'd12,
      6'd13, 6'd14, 6'd15, 6'd17, 6'd18, 6'd19, 6'd20, 6'd21,
      6'd22, 6'd23, 6'd24, 6'd25, 6'd26, 6'd27, 6'd28, 6'd29,
      6'd30, 6'd31, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd38
   };

   typedef logic [line_data_width-1:0]  line_data_t;
   typedef logic [line_ecc_width-1:0]   line_ecc_t;
   typedef logic [array_word_width-1:0] array_word_t;
   typedef logic [lane_data_width-1:0]  lane_data_t;
   typedef logic [lane_ecc_width-1:0]   lane_ecc_t;
   typedef logic [lane_count-1:0]       lane_mask_t;

endpackage

`default_nettype wire
